// ==== logic/mipsPkg.sv ====
// shared opcode, funct and ALU encodings plus the control word used across the MIPS core
package mipsPkg;

  // ************************************************************************
  // instruction fields
  // ************************************************************************

  // primary opcode, bits 31:26
  typedef enum logic [5:0] {
    opRtype = 6'b000000,
    opLw    = 6'b100011,
    opSw    = 6'b101011,
    opBeq   = 6'b000100
  } opcodeE;

  // R-type function field, bits 5:0
  typedef enum logic [5:0] {
    fnAdd = 6'b100000,
    fnSub = 6'b100010,
    fnAnd = 6'b100100,
    fnOr  = 6'b100101,
    fnSlt = 6'b101010
  } functE;

  // ************************************************************************
  // control
  // ************************************************************************

  typedef enum logic [2:0] {
    aluAnd = 3'b000,
    aluOr  = 3'b001,
    aluAdd = 3'b010,
    aluSub = 3'b110,
    aluSlt = 3'b111
  } aluOpE;

  // one word steering the whole datapath for the current instruction
  typedef struct packed {
    logic  regWrite;
    logic  regDst;
    logic  aluSrc;
    logic  branch;
    logic  memWrite;
    logic  memToReg;
    aluOpE aluOp;
  } ctrlSignalsS;

endpackage

// ==== logic/mainDecoder.sv ====
// opcode decoder producing the datapath steering controls; instantiated by controlUnit
`timescale 1ns/1ps

module mainDecoder (
  input  mipsPkg::opcodeE opcode,
  output logic            regWrite,
  output logic            regDst,
  output logic            aluSrc,
  output logic            branch,
  output logic            memWrite,
  output logic            memToReg,
  output logic            known
);

  always_comb begin
    // safe defaults, also what an unknown opcode gets
    regWrite = 1'b0;
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    branch   = 1'b0;
    memWrite = 1'b0;
    memToReg = 1'b0;
    known    = 1'b1;
    case (opcode)
      mipsPkg::opRtype: begin
        regWrite = 1'b1;
        regDst   = 1'b1;
      end
      mipsPkg::opLw: begin
        regWrite = 1'b1;
        aluSrc   = 1'b1;
        memToReg = 1'b1;
      end
      // regDst and memToReg are don't care for sw, left at 0
      mipsPkg::opSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      mipsPkg::opBeq: begin
        branch = 1'b1;
      end
      default: begin
        known = 1'b0;
      end
    endcase
  end

endmodule

// ==== logic/aluDecoder.sv ====
// decodes opcode and funct straight into an ALU operation; instantiated by controlUnit
`timescale 1ns/1ps

module aluDecoder (
  input  mipsPkg::opcodeE opcode,
  input  mipsPkg::functE  funct,
  output mipsPkg::aluOpE  aluOp,
  output logic            known
);

  always_comb begin
    aluOp = mipsPkg::aluAdd;
    known = 1'b1;
    case (opcode)
      // address calculation for loads and stores
      mipsPkg::opLw,
      mipsPkg::opSw: begin
        aluOp = mipsPkg::aluAdd;
      end
      // compare by subtraction, zero flag decides
      mipsPkg::opBeq: begin
        aluOp = mipsPkg::aluSub;
      end
      mipsPkg::opRtype: begin
        case (funct)
          mipsPkg::fnAdd: aluOp = mipsPkg::aluAdd;
          mipsPkg::fnSub: aluOp = mipsPkg::aluSub;
          mipsPkg::fnAnd: aluOp = mipsPkg::aluAnd;
          mipsPkg::fnOr:  aluOp = mipsPkg::aluOr;
          mipsPkg::fnSlt: aluOp = mipsPkg::aluSlt;
          default: begin
            known = 1'b0;
          end
        endcase
      end
      default: begin
        known = 1'b0;
      end
    endcase
  end

endmodule

// ==== logic/controlUnit.sv ====
// runs both decoders in parallel and merges them into one control word; used by mipsCore
`timescale 1ns/1ps

module controlUnit (
  input  logic                 rst,
  input  mipsPkg::opcodeE      opcode,
  input  mipsPkg::functE       funct,
  output mipsPkg::ctrlSignalsS ctrl,
  output logic                 illegal
);

  logic           regWrite;
  logic           regDst;
  logic           aluSrc;
  logic           branch;
  logic           memWrite;
  logic           memToReg;
  logic           mainKnown;
  logic           aluKnown;
  mipsPkg::aluOpE aluOp;

  mainDecoder u_mainDecoder (
    .opcode   (opcode),
    .regWrite (regWrite),
    .regDst   (regDst),
    .aluSrc   (aluSrc),
    .branch   (branch),
    .memWrite (memWrite),
    .memToReg (memToReg),
    .known    (mainKnown)
  );

  aluDecoder u_aluDecoder (
    .opcode (opcode),
    .funct  (funct),
    .aluOp  (aluOp),
    .known  (aluKnown)
  );

  assign illegal = ~(mainKnown & aluKnown);

  always_comb begin
    if (rst || illegal) begin
      // inactive word, instruction behaves as a no-op
      ctrl.regWrite = 1'b0;
      ctrl.regDst   = 1'b0;
      ctrl.aluSrc   = 1'b0;
      ctrl.branch   = 1'b0;
      ctrl.memWrite = 1'b0;
      ctrl.memToReg = 1'b0;
      ctrl.aluOp    = mipsPkg::aluAnd;
    end else begin
      ctrl.regWrite = regWrite;
      ctrl.regDst   = regDst;
      ctrl.aluSrc   = aluSrc;
      ctrl.branch   = branch;
      ctrl.memWrite = memWrite;
      ctrl.memToReg = memToReg;
      ctrl.aluOp    = aluOp;
    end
  end

endmodule

// ==== logic/regFile.sv ====
// 32 x 32-bit register file, two combinational reads and one clocked write; used by dataPath
`timescale 1ns/1ps

module regFile (
  input  logic        clk,
  input  logic        rst,
  input  logic        we,
  input  logic [4:0]  ra1,
  input  logic [4:0]  ra2,
  input  logic [4:0]  wa,
  input  logic [31:0] wd,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'h0;
      end
    end else if (we && (wa != 5'd0)) begin
      // writes to $zero are dropped
      regs[wa] <= wd;
    end
  end

  // $zero is hardwired, whatever the array holds
  assign rd1 = (ra1 == 5'd0) ? 32'h0 : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? 32'h0 : regs[ra2];

endmodule

// ==== logic/alu.sv ====
// 32-bit ALU for and, or, add, sub and signed slt with a zero flag; used by dataPath
`timescale 1ns/1ps

module alu (
  input  logic [31:0]    a,
  input  logic [31:0]    b,
  input  mipsPkg::aluOpE op,
  output logic [31:0]    y,
  output logic           zero
);

  always_comb begin
    case (op)
      mipsPkg::aluAnd: y = a & b;
      mipsPkg::aluOr:  y = a | b;
      mipsPkg::aluAdd: y = a + b;
      mipsPkg::aluSub: y = a - b;
      // signed compare, result is 0 or 1
      mipsPkg::aluSlt: y = {31'h0, $signed(a) < $signed(b)};
      default:         y = 32'h0;
    endcase
  end

  // beq takes the branch when a - b is zero
  assign zero = (y == 32'h0);

endmodule

// ==== logic/dataPath.sv ====
// single-cycle MIPS datapath with pc, register file, ALU and result muxes; used by mipsCore
`timescale 1ns/1ps

module dataPath #(
  parameter logic [31:0] ResetPc = 32'h0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  mipsPkg::ctrlSignalsS ctrl,
  input  logic [31:0]          instr,
  input  logic [31:0]          readData,
  output logic [31:0]          pc,
  output logic [31:0]          dataAddr,
  output logic [31:0]          writeData
);

  logic [31:0] pcReg;
  logic [31:0] pcNext;
  logic [31:0] pcPlus4;
  logic [31:0] pcBranch;
  logic        pcSrc;
  logic [31:0] signImm;
  logic [4:0]  writeReg;
  logic [31:0] result;
  logic [31:0] srcA;
  logic [31:0] srcB;
  logic [31:0] rd2;
  logic [31:0] aluY;
  logic        zero;

  // ************************************************************************
  // program counter
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      pcReg <= ResetPc;
    end else begin
      pcReg <= pcNext;
    end
  end

  assign pcPlus4  = pcReg + 32'd4;
  // word offset relative to the delay-free next pc
  assign pcBranch = pcPlus4 + {signImm[29:0], 2'b00};
  assign pcSrc    = ctrl.branch & zero;
  assign pcNext   = pcSrc ? pcBranch : pcPlus4;
  assign pc       = pcReg;

  // ************************************************************************
  // register file and operands
  // ************************************************************************

  assign signImm  = {{16{instr[15]}}, instr[15:0]};
  // rd for R-type, rt for lw
  assign writeReg = ctrl.regDst ? instr[15:11] : instr[20:16];
  assign result   = ctrl.memToReg ? readData : aluY;

  regFile u_regFile (
    .clk (clk),
    .rst (rst),
    .we  (ctrl.regWrite),
    .ra1 (instr[25:21]),
    .ra2 (instr[20:16]),
    .wa  (writeReg),
    .wd  (result),
    .rd1 (srcA),
    .rd2 (rd2)
  );

  assign srcB = ctrl.aluSrc ? signImm : rd2;

  // ************************************************************************
  // execute and memory
  // ************************************************************************

  alu u_alu (
    .a    (srcA),
    .b    (srcB),
    .op   (ctrl.aluOp),
    .y    (aluY),
    .zero (zero)
  );

  // address from base plus offset, store data straight from rt
  assign dataAddr  = aluY;
  assign writeData = rd2;

endmodule

// ==== logic/mipsCore.sv ====
// top of the single-cycle MIPS core, wiring control and datapath to the memory ports
`timescale 1ns/1ps

module mipsCore #(
  parameter logic [31:0] ResetPc = 32'h0
) (
  input  logic        clk,
  input  logic        rst,
  output logic [31:0] pc,
  input  logic [31:0] instr,
  output logic [31:0] dataAddr,
  output logic [31:0] writeData,
  output logic        memWrite,
  input  logic [31:0] readData,
  output logic        illegal
);

  mipsPkg::ctrlSignalsS ctrl;

  // opcode and funct fields go to the decoders as raw bits
  controlUnit u_controlUnit (
    .rst     (rst),
    .opcode  (mipsPkg::opcodeE'(instr[31:26])),
    .funct   (mipsPkg::functE'(instr[5:0])),
    .ctrl    (ctrl),
    .illegal (illegal)
  );

  dataPath #(
    .ResetPc (ResetPc)
  ) u_dataPath (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .instr     (instr),
    .readData  (readData),
    .pc        (pc),
    .dataAddr  (dataAddr),
    .writeData (writeData)
  );

  assign memWrite = ctrl.memWrite;

endmodule

// ==== bench/clockGen.sv ====
// testbench clock and reset source: 8 ns clock, reset held high for the first cycles
`timescale 1ns/1ps

module clockGen #(
  parameter int HalfPeriod  = 4,
  parameter int ResetCycles = 10
) (
  output logic clk,
  output logic rst
);

  always #(HalfPeriod) clk = ~clk;

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== bench/mipsCore_props.sv ====
// concurrent checks on write enables and pc sequencing, bound into every mipsCore instance
`timescale 1ns/1ps

module mipsCoreProps (
  input logic        clk,
  input logic        rst,
  input logic [31:0] pc,
  input logic [31:0] instr,
  input logic        memWrite,
  input logic        illegal
);

  logic [31:0] branchTarget;
  int          failCount = 0;

  // beq target is pc + 4 plus the word offset
  assign branchTarget = pc + 32'd4 + {{14{instr[15]}}, instr[15:0], 2'b00};

  noStoreInReset: assert property (@(posedge clk) rst |-> !memWrite)
    else begin
      failCount++;
      $error("memWrite high during reset");
    end

  noStoreWhenIllegal: assert property (@(posedge clk) disable iff (rst) illegal |-> !memWrite)
    else begin
      failCount++;
      $error("memWrite high on an illegal instruction");
    end

  pcStep: assert property (@(posedge clk) disable iff (rst)
    !rst |=> (pc == $past(pc) + 32'd4) || (pc == $past(branchTarget)))
    else begin
      failCount++;
      $error("pc moved by neither 4 nor a branch offset");
    end

endmodule

bind mipsCore mipsCoreProps u_props (
  .clk(clk), .rst(rst), .pc(pc), .instr(instr), .memWrite(memWrite), .illegal(illegal)
);

// ==== bench/mipsChecker.sv ====
// watches fetch, store and illegal outputs of the core each cycle and compares them to the table
`timescale 1ns/1ps

module mipsChecker #(
  parameter logic [31:0] ResetPc = 32'h0,
  parameter int          Entries = 1
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] pc,
  input  logic        memWrite,
  input  logic [31:0] dataAddr,
  input  logic [31:0] writeData,
  input  logic        illegal,
  input  logic        expWr      [Entries],
  input  logic [31:0] expAddr    [Entries],
  input  logic [31:0] expData    [Entries],
  input  logic        expIllegal [Entries],
  input  logic        expTaken   [Entries],
  output logic        done,
  output int          errors
);

  // table row the core should be executing now
  int idx;

  function automatic int countMismatch(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h at step %0d", $time, what, got, exp, idx);
      return 1;
    end
    return 0;
  endfunction

  always @(posedge clk) begin
    int bad;
    int nextIdx;
    bad = 0;
    if (rst) begin
      idx    <= 0;
      done   <= 1'b0;
      errors <= 0;
    end else if (!done) begin
      bad += countMismatch("pc", pc, ResetPc + 32'(idx) * 32'd4);
      bad += countMismatch("illegal", 32'(illegal), 32'(expIllegal[idx]));
      bad += countMismatch("memWrite", 32'(memWrite), 32'(expWr[idx]));
      if (memWrite && expWr[idx]) begin
        bad += countMismatch("dataAddr", dataAddr, expAddr[idx]);
        bad += countMismatch("writeData", writeData, expData[idx]);
      end
      // a taken beq skips one row
      nextIdx = expTaken[idx] ? idx + 2 : idx + 1;
      idx     <= nextIdx;
      done    <= (nextIdx >= Entries);
      errors  <= errors + bad;
    end
  end

endmodule

// ==== bench/mipsTb.sv ====
// testbench top for the MIPS core: memory models, program table, checker hookup, final report
`timescale 1ns/1ps

module mipsTb;

  localparam logic [31:0] ResetPc    = 32'h0000_0040;
  localparam int          Entries    = 26;
  localparam int          MemWords   = 64;
  localparam int          ResetLimit = 50;
  localparam int          RunLimit   = 200;

  logic        clk;
  logic        rst;
  logic [31:0] pc, instr, dataAddr, writeData, readData;
  logic        memWrite, illegal, done;
  int          errors, timeouts, cycles, n;
  logic [31:0] imem [MemWords];
  logic [31:0] dmem [MemWords];
  logic [31:0] p [4];

  // program table, one row per instruction slot
  logic [31:0] progInstr [Entries];
  logic        expWr [Entries], expIllegal [Entries], expTaken [Entries];
  logic [31:0] expAddr [Entries], expData [Entries];

  clockGen #(.HalfPeriod(4), .ResetCycles(10)) u_clk (.*);
  mipsCore #(.ResetPc(ResetPc)) u_dut (.*);
  mipsChecker #(.ResetPc(ResetPc), .Entries(Entries)) u_chk (.*);

  // both memories read combinationally, stores land on the edge
  assign instr    = imem[pc[7:2]];
  assign readData = dmem[dataAddr[7:2]];

  always @(posedge clk) begin
    if (memWrite) begin
      dmem[dataAddr[7:2]] <= writeData;
    end
  end

  function automatic logic [31:0] rType(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                        logic [5:0] funct);
    return {6'b000000, rs, rt, rd, 5'b00000, funct};
  endfunction

  function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                        logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic addEntry(input logic [31:0] word, input logic wr, input logic [31:0] addr,
                          input logic [31:0] data, input logic ill, input logic taken);
    progInstr[n]  = word;
    expWr[n]      = wr;
    expAddr[n]    = addr;
    expData[n]    = data;
    expIllegal[n] = ill;
    expTaken[n]   = taken;
    n++;
  endtask

  task automatic addStore(input logic [4:0] rt, input logic [15:0] offset, input logic [31:0] data);
    addEntry(iType(mipsPkg::opSw, 5'd0, rt, offset), 1'b1, {16'h0, offset}, data, 1'b0, 1'b0);
  endtask

  task automatic buildProgram();
    n = 0;
    // a store sits at the reset address for the whole reset, $1 is still clear
    addStore(5'd1, 16'h0098, 32'h0);
    addEntry(iType(mipsPkg::opLw, 5'd0, 5'd1, 16'h0000), 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
    addEntry(iType(mipsPkg::opLw, 5'd0, 5'd2, 16'h0004), 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
    addEntry(iType(mipsPkg::opLw, 5'd0, 5'd3, 16'h0008), 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
    // every ALU result is stored so it shows on the data port
    addEntry(rType(5'd1, 5'd2, 5'd5, mipsPkg::fnAdd), 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
    addStore(5'd5, 16'h0080, p[0] + p[1]);
    addEntry(rType(5'd1, 5'd2, 5'd6, mipsPkg::fnSub), 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
    addStore(5'd6, 16'h0084, p[0] - p[1]);
    addEntry(rType(5'd1, 5'd3, 5'd7, mipsPkg::fnAnd), 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
    addStore(5'd7, 16'h0088, p[0] & p[2]);
    addEntry(rType(5'd2, 5'd3, 5'd8, mipsPkg::fnOr), 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
    addStore(5'd8, 16'h008c, p[1] | p[2]);
    addEntry(rType(5'd1, 5'd2, 5'd9, mipsPkg::fnSlt), 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
    // differing signs decide alone, equal signs order like unsigned values
    addStore(5'd9, 16'h0090, {31'h0, (p[0][31] != p[1][31]) ? p[0][31] : (p[0] < p[1])});
    // load then store of the same register
    addEntry(iType(mipsPkg::opLw, 5'd0, 5'd4, 16'h000c), 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
    addStore(5'd4, 16'h0094, p[3]);
    // beq $1,$1 is always taken, the store behind it never runs
    addEntry(iType(mipsPkg::opBeq, 5'd1, 5'd1, 16'h0001), 1'b0, 32'h0, 32'h0, 1'b0, 1'b1);
    addStore(5'd1, 16'h00a0, p[0]);
    addEntry(iType(mipsPkg::opBeq, 5'd1, 5'd2, 16'h0001), 1'b0, 32'h0, 32'h0, 1'b0, p[0] == p[1]);
    addStore(5'd2, 16'h00a4, p[1]);
    // unknown opcode aimed at $1, unknown funct aimed at $10
    addEntry({6'b111111, 5'd0, 5'd1, 16'h0008}, 1'b0, 32'h0, 32'h0, 1'b1, 1'b0);
    addEntry(rType(5'd1, 5'd2, 5'd10, 6'b100111), 1'b0, 32'h0, 32'h0, 1'b1, 1'b0);
    addStore(5'd10, 16'h00a8, 32'h0);
    addStore(5'd1, 16'h00ac, p[0]);
    // writes to $zero are lost
    addEntry(rType(5'd1, 5'd2, 5'd0, mipsPkg::fnAdd), 1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
    addStore(5'd0, 16'h00b0, 32'h0);
  endtask

  initial begin
    logic [31:0] w;
    void'($urandom(1855));
    for (int i = 0; i < MemWords; i++) begin
      w = $urandom();
      dmem[i] <= w;
      if (i < 4) begin
        p[i] = w;
      end
    end
    buildProgram();
    for (int i = 0; i < MemWords; i++) begin
      imem[i] = 32'h0;
    end
    // table rows fill instruction memory from the reset address on
    for (int i = 0; i < Entries; i++) begin
      imem[ResetPc[7:2] + i] = progInstr[i];
    end
    timeouts = 0;
    cycles   = 0;
    while (rst !== 1'b0 && cycles < ResetLimit) begin
      @(posedge clk);
      cycles++;
    end
    if (rst !== 1'b0) begin
      $display("Timeout: reset was still asserted after %0d cycles", ResetLimit);
      timeouts++;
    end
    cycles = 0;
    while (done !== 1'b1 && cycles < RunLimit) begin
      @(posedge clk);
      cycles++;
    end
    if (done !== 1'b1) begin
      $display("Timeout: the program did not complete within %0d cycles", RunLimit);
      timeouts++;
    end
    $display("Errors: checker %0d, assertions %0d, timeouts %0d",
             errors, u_dut.u_props.failCount, timeouts);
    if (errors == 0 && u_dut.u_props.failCount == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
logic/mipsPkg.sv
logic/mainDecoder.sv
logic/aluDecoder.sv
logic/controlUnit.sv
logic/regFile.sv
logic/alu.sv
logic/dataPath.sv
logic/mipsCore.sv
bench/clockGen.sv
bench/mipsCore_props.sv
bench/mipsChecker.sv
bench/mipsTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mipsTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIMARGS   ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIMARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
